/* filelist.f */
hdl/exec_pkg.sv
hdl/alu_decoder.sv
hdl/imm_gen.sv
hdl/alu.sv
hdl/branch_unit.sv
hdl/exec_stage.sv
sim/tb_clock.sv
sim/exec_checker.sv
sim/tb_exec_stage.sv

/* Makefile */
# Verilator flow for the execute stage; every variable can be overridden on the command line

VERILATOR ?= verilator
FILELIST  ?= filelist.f
TOP       ?= tb_exec_stage
RTL_TOP   ?= exec_stage
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
JOBS      ?= 0
PASS_MSG  ?= All tests passed!

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) --Mdir $(OBJ_DIR) \
		-f $(FILELIST) --top-module $(TOP)

# status comes from the search for the pass message
sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* sim/tb_exec_stage.sv */
// testbench top for the execute stage, drives random rv32i instructions and reports the outcome
`timescale 1ns/1ps

module tb_exec_stage;
	import exec_pkg::*;

	localparam int num_cycles    = 3000;
	localparam int reset_timeout = 50;
	localparam int drain_timeout = 20;

	logic        clk;
	logic        arst_n;
	exec_in_t    ex_in;
	exec_out_t   ex_out;
	int          error_count;
	int          check_count;
	int          pending;
	int          timeouts;
	logic [31:0] lcg_state;

	tb_clock tb_clock_inst (
		.clk    (clk),
		.arst_n (arst_n)
	);

	exec_stage exec_stage_inst (
		.clk    (clk),
		.arst_n (arst_n),
		.ex_in  (ex_in),
		.ex_out (ex_out)
	);

	exec_checker exec_checker_inst (
		.clk         (clk),
		.arst_n      (arst_n),
		.ex_in       (ex_in),
		.ex_out      (ex_out),
		.error_count (error_count),
		.check_count (check_count),
		.pending     (pending)
	);

	function automatic logic [31:0] next_random();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// upper lcg bits since the low ones cycle too quickly
	function automatic int random_below(input int n);
		return int'((next_random() >> 8) % n);
	endfunction

	// boundary values half of the time
	function automatic word_t pick_operand();
		case (random_below(8))
			0: return 32'h8000_0000;
			1: return 32'h7fff_ffff;
			2: return 32'h0000_0000;
			3: return 32'hffff_ffff;
			default: return next_random();
		endcase
	endfunction

	// about one in ten illegal and the rest spread over the seven opcodes
	function automatic instr_t build_instr();
		instr_t ins;
		int     kind;
		ins  = next_random();
		kind = random_below(20);
		if (kind == 0) begin
			case (random_below(4))
				0: ins[6:0] = 7'b0000011;
				1: ins[6:0] = 7'b0100011;
				2: ins[6:0] = 7'b1110011;
				default: ins[6:0] = 7'b0001111;
			endcase
		end else if (kind == 1) begin
			case (random_below(4))
				0: begin
					ins[6:0]   = op_reg;
					ins[31:25] = {1'b1, ins[30:25]};
				end
				1: begin
					ins[6:0]   = op_imm;
					ins[14:12] = 3'd1;
					ins[31:25] = 7'h20;
				end
				2: begin
					ins[6:0]   = op_branch;
					ins[14:12] = 3'd2 + 3'(random_below(2));
				end
				default: begin
					ins[6:0]   = op_jalr;
					ins[14:12] = 3'd1 + 3'(random_below(7));
				end
			endcase
		end else if (kind < 6) begin
			ins[6:0]   = op_reg;
			ins[31:25] = 7'h00;
			if ((ins[14:12] == 3'd0 || ins[14:12] == 3'd5) && random_below(2) == 1)
				ins[31:25] = 7'h20;
		end else if (kind < 10) begin
			ins[6:0] = op_imm;
			if (ins[14:12] == 3'd1)
				ins[31:25] = 7'h00;
			if (ins[14:12] == 3'd5)
				ins[31:25] = (random_below(2) == 1) ? 7'h20 : 7'h00;
		end else if (kind == 10) begin
			ins[6:0] = op_lui;
		end else if (kind == 11) begin
			ins[6:0] = op_auipc;
		end else if (kind < 16) begin
			ins[6:0] = op_branch;
			case (random_below(6))
				0: ins[14:12] = 3'd0;
				1: ins[14:12] = 3'd1;
				2: ins[14:12] = 3'd4;
				3: ins[14:12] = 3'd5;
				4: ins[14:12] = 3'd6;
				default: ins[14:12] = 3'd7;
			endcase
		end else if (kind < 18) begin
			ins[6:0] = op_jal;
		end else begin
			ins[6:0]   = op_jalr;
			ins[14:12] = 3'd0;
		end
		return ins;
	endfunction

	task automatic issue(input logic v, input instr_t ins, input addr_t pc,
		input word_t a, input word_t b);
		@(posedge clk);
		ex_in.valid    <= v;
		ex_in.instr    <= ins;
		ex_in.pc       <= pc;
		ex_in.rs1_data <= a;
		ex_in.rs2_data <= b;
	endtask

	initial begin
		word_t a;
		word_t b;
		int    wait_cycles;
		ex_in     = '0;
		lcg_state = 32'hd46b_bb8c;
		timeouts  = 0;

		// valid instructions during reset must never reach the output
		wait_cycles = 0;
		while (arst_n !== 1'b1 && wait_cycles < reset_timeout) begin
			issue(1'b1, build_instr(), next_random() & ~32'd3, next_random(),
				next_random());
			wait_cycles++;
		end
		if (arst_n !== 1'b1) begin
			timeouts++;
			$display("reset was not released within %0d cycles", reset_timeout);
		end else begin
			// slt and sltu across the sign boundary and with equal operands
			issue(1'b1, {7'h00, 5'd2, 5'd1, 3'd2, 5'd3, op_reg}, 32'h100,
				32'h8000_0000, 32'h7fff_ffff);
			issue(1'b1, {7'h00, 5'd2, 5'd1, 3'd2, 5'd3, op_reg}, 32'h104,
				32'h7fff_ffff, 32'h8000_0000);
			issue(1'b1, {7'h00, 5'd2, 5'd1, 3'd3, 5'd3, op_reg}, 32'h108,
				32'h8000_0000, 32'h7fff_ffff);
			issue(1'b1, {7'h00, 5'd2, 5'd1, 3'd3, 5'd3, op_reg}, 32'h10c,
				32'h7fff_ffff, 32'h8000_0000);
			issue(1'b1, {7'h00, 5'd2, 5'd1, 3'd2, 5'd3, op_reg}, 32'h110,
				32'h8000_0000, 32'h8000_0000);
			issue(1'b1, {7'h00, 5'd2, 5'd1, 3'd3, 5'd3, op_reg}, 32'h114,
				32'h7fff_ffff, 32'h7fff_ffff);

			for (int n = 0; n < num_cycles; n++) begin
				a = pick_operand();
				b = (random_below(8) == 0) ? a : pick_operand();
				issue(random_below(4) != 0, build_instr(), next_random() & ~32'd3, a, b);
			end
			issue(1'b0, '0, '0, '0, '0);

			wait_cycles = 0;
			@(negedge clk);
			while (pending != 0 && wait_cycles < drain_timeout) begin
				@(negedge clk);
				wait_cycles++;
			end
			if (pending != 0) begin
				timeouts++;
				$display("%0d expected outputs never arrived", pending);
			end
		end

		$display("checks %0d, errors %0d, timeouts %0d", check_count, error_count, timeouts);
		if (error_count == 0 && timeouts == 0 && check_count > 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

/* sim/exec_checker.sv */
// watches the execute stage ports, models each instruction and compares every registered output
`timescale 1ns/1ps

module exec_checker (
	input  logic                clk,
	input  logic                arst_n,
	input  exec_pkg::exec_in_t  ex_in,
	input  exec_pkg::exec_out_t ex_out,
	output int                  error_count,
	output int                  check_count,
	output int                  pending
);
	import exec_pkg::*;

	// expected output plus which payload fields carry meaning
	typedef struct packed {
		exec_out_t out;
		logic      chk_data;
		logic      chk_target;
	} expect_t;

	expect_t exp_q[$];
	int      errors;
	int      checks;
	int      queued;

	assign error_count = errors;
	assign check_count = checks;
	assign pending     = queued;

	initial begin
		errors = 0;
		checks = 0;
		queued = 0;
	end

	// reference arithmetic per funct3, shift amount masked to five bits
	function automatic word_t arith_result(input logic [2:0] f3, input logic alt,
		input word_t a, input word_t b);
		case (f3)
			3'd0: return alt ? a - b : a + b;
			3'd1: return a << b[4:0];
			3'd2: return {31'b0, $signed(a) < $signed(b)};
			3'd3: return {31'b0, a < b};
			3'd4: return a ^ b;
			3'd5: begin
				if (alt)
					return $signed(a) >>> b[4:0];
				return a >> b[4:0];
			end
			3'd6: return a | b;
			default: return a & b;
		endcase
	endfunction

	// behavioral model of one instruction, straight from the rv32i encoding
	function automatic expect_t expected_output(input exec_in_t in);
		expect_t    e;
		logic [6:0] opc;
		logic [2:0] f3;
		logic [6:0] f7;
		word_t      a;
		word_t      b;
		word_t      i_imm;
		word_t      u_imm;
		word_t      b_imm;
		word_t      j_imm;
		logic       legal;
		logic       writes;
		opc    = in.instr[6:0];
		f3     = in.instr[14:12];
		f7     = in.instr[31:25];
		a      = in.rs1_data;
		b      = in.rs2_data;
		i_imm  = {{20{in.instr[31]}}, in.instr[31:20]};
		u_imm  = {in.instr[31:12], 12'h000};
		b_imm  = {{20{in.instr[31]}}, in.instr[7], in.instr[30:25], in.instr[11:8], 1'b0};
		j_imm  = {{12{in.instr[31]}}, in.instr[19:12], in.instr[20], in.instr[30:21], 1'b0};
		legal  = 1'b1;
		writes = 1'b0;
		e      = '0;
		e.out.valid = 1'b1;
		e.out.rd    = in.instr[11:7];
		case (opc)
			op_reg: begin
				writes = 1'b1;
				legal  = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
				e.out.rd_data = arith_result(f3, f7[5], a, b);
			end
			op_imm: begin
				writes = 1'b1;
				// funct7 only constrains the shifts
				if (f3 == 3'd1)
					legal = (f7 == 7'h00);
				if (f3 == 3'd5)
					legal = (f7 == 7'h00) || (f7 == 7'h20);
				e.out.rd_data = arith_result(f3, f3 == 3'd5 && f7[5], a, i_imm);
			end
			op_lui: begin
				writes = 1'b1;
				e.out.rd_data = u_imm;
			end
			op_auipc: begin
				writes = 1'b1;
				e.out.rd_data = in.pc + u_imm;
			end
			op_branch: begin
				case (f3)
					3'd0: e.out.redirect = (a == b);
					3'd1: e.out.redirect = (a != b);
					3'd4: e.out.redirect = ($signed(a) < $signed(b));
					3'd5: e.out.redirect = ($signed(a) >= $signed(b));
					3'd6: e.out.redirect = (a < b);
					3'd7: e.out.redirect = (a >= b);
					default: legal = 1'b0;
				endcase
				e.out.target = in.pc + b_imm;
				e.chk_target = 1'b1;
			end
			op_jal: begin
				writes = 1'b1;
				e.out.rd_data  = in.pc + 32'd4;
				e.out.redirect = 1'b1;
				e.out.target   = in.pc + j_imm;
				e.chk_target   = 1'b1;
			end
			op_jalr: begin
				writes = 1'b1;
				legal  = (f3 == 3'd0);
				e.out.rd_data  = in.pc + 32'd4;
				e.out.redirect = 1'b1;
				// target is always even
				e.out.target   = (a + i_imm) & ~32'd1;
				e.chk_target   = 1'b1;
			end
			default: legal = 1'b0;
		endcase
		e.chk_data     = legal && writes;
		e.out.rd_wen   = legal && writes && (e.out.rd != 5'd0);
		e.out.illegal  = !legal;
		if (!legal) begin
			e.out.redirect = 1'b0;
			e.chk_target   = 1'b0;
		end
		return e;
	endfunction

	task automatic compare_output(input expect_t e);
		logic bad;
		bad = 1'b0;
		if (ex_out.rd !== e.out.rd || ex_out.rd_wen !== e.out.rd_wen ||
			ex_out.redirect !== e.out.redirect || ex_out.illegal !== e.out.illegal)
			bad = 1'b1;
		if (e.chk_data && ex_out.rd_data !== e.out.rd_data)
			bad = 1'b1;
		if (e.chk_target && ex_out.target !== e.out.target)
			bad = 1'b1;
		checks++;
		if (bad) begin
			errors++;
			$display("error %0t: got rd %0d wen %b data %h redirect %b target %h illegal %b",
				$time, ex_out.rd, ex_out.rd_wen, ex_out.rd_data, ex_out.redirect,
				ex_out.target, ex_out.illegal);
			$display("error %0t: want rd %0d wen %b data %h redirect %b target %h illegal %b",
				$time, e.out.rd, e.out.rd_wen, e.out.rd_data, e.out.redirect,
				e.out.target, e.out.illegal);
		end
	endtask

	// outputs are compared before the new input is queued, both seen at the same edge
	always @(posedge clk) begin : sample
		expect_t e;
		if (!arst_n) begin
			if (ex_out.valid !== 1'b0) begin
				errors++;
				$display("output valid raised during reset at %0t", $time);
			end
			exp_q.delete();
		end else begin
			if (ex_out.valid === 1'b1) begin
				if (exp_q.size() == 0) begin
					errors++;
					$display("output at %0t with no instruction one cycle earlier", $time);
				end else begin
					e = exp_q.pop_front();
					compare_output(e);
				end
			end else if (exp_q.size() != 0) begin
				// one cycle latency, anything older is lost
				errors++;
				$display("missing output at %0t for an instruction one cycle earlier", $time);
				void'(exp_q.pop_front());
			end
			if (ex_in.valid === 1'b1)
				exp_q.push_back(expected_output(ex_in));
		end
		queued = exp_q.size();
	end

endmodule

/* sim/tb_clock.sv */
// clock and reset source for the execute stage testbench, 8 ns clock and a 10 cycle reset
`timescale 1ns/1ps

module tb_clock (
	output logic clk,
	output logic arst_n
);
	// half of the 8 ns period
	localparam real half_period_ns = 4.0;
	localparam int  reset_cycles   = 10;

	initial begin
		clk = 1'b0;
		forever #(half_period_ns) clk = ~clk;
	end

	// reset held low, released on a rising edge
	initial begin
		arst_n = 1'b0;
		repeat (reset_cycles) @(posedge clk);
		arst_n <= 1'b1;
	end

endmodule

/* hdl/exec_stage.sv */
// top of the execute stage, decodes, computes and registers one instruction per valid strobe
`timescale 1ns/1ps

module exec_stage (
	input  logic                clk,
	input  logic                arst_n,
	input  exec_pkg::exec_in_t  ex_in,
	output exec_pkg::exec_out_t ex_out
);
	import exec_pkg::*;

	dec_t     dec;
	word_t    imm;
	word_t    operand_a;
	word_t    operand_b;
	word_t    alu_result;
	logic     alu_zero;
	logic     taken;
	addr_t    target;
	word_t    link;
	word_t    rd_data;
	reg_idx_t rd;

	// control flops, cleared on reset
	logic     valid_q;
	logic     rd_wen_q;
	logic     redirect_q;
	logic     illegal_q;
	// payload flops, loaded only with a valid instruction
	reg_idx_t rd_q;
	word_t    rd_data_q;
	addr_t    target_q;

	alu_decoder alu_decoder_inst (
		.instr (ex_in.instr),
		.dec   (dec)
	);

	imm_gen imm_gen_inst (
		.instr (ex_in.instr),
		.fmt   (dec.imm_fmt),
		.imm   (imm)
	);

	// auipc adds to the pc, immediate forms take imm as b
	assign operand_a = dec.a_is_pc ? ex_in.pc : ex_in.rs1_data;
	assign operand_b = dec.b_is_imm ? imm : ex_in.rs2_data;

	alu alu_inst (
		.src1   (operand_a),
		.src2   (operand_b),
		.op     (dec.alu_op),
		.result (alu_result),
		.zero   (alu_zero)
	);

	branch_unit branch_unit_inst (
		.funct3   (ex_in.instr[14:12]),
		.dec      (dec),
		.result   (alu_result),
		.zero     (alu_zero),
		.pc       (ex_in.pc),
		.imm      (imm),
		.rs1_data (ex_in.rs1_data),
		.taken    (taken),
		.target   (target),
		.link     (link)
	);

	assign rd = ex_in.instr[11:7];
	// jumps write the return address
	assign rd_data = (dec.is_jal | dec.is_jalr) ? link : alu_result;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			valid_q    <= 1'b0;
			rd_wen_q   <= 1'b0;
			redirect_q <= 1'b0;
			illegal_q  <= 1'b0;
		end else begin
			// flags only live for the cycle after a valid strobe
			valid_q    <= ex_in.valid;
			rd_wen_q   <= ex_in.valid & dec.rd_wen;
			redirect_q <= ex_in.valid & taken;
			illegal_q  <= ex_in.valid & dec.illegal;
		end
	end

	always_ff @(posedge clk) begin
		if (ex_in.valid) begin
			rd_q      <= rd;
			rd_data_q <= rd_data;
			target_q  <= target;
		end
	end

	always_comb begin
		ex_out.valid    = valid_q;
		ex_out.rd       = rd_q;
		ex_out.rd_wen   = rd_wen_q;
		ex_out.rd_data  = rd_data_q;
		ex_out.redirect = redirect_q;
		ex_out.target   = target_q;
		ex_out.illegal  = illegal_q;
	end

	// a redirect never shows without a valid output
	a_redirect_valid: assert property (@(posedge clk) disable iff (!arst_n)
		ex_out.redirect |-> ex_out.valid);

endmodule

/* hdl/branch_unit.sv */
// resolves branch and jump outcome, computes the redirect target and the link value
`timescale 1ns/1ps

module branch_unit (
	input  logic [2:0]      funct3,
	input  exec_pkg::dec_t  dec,
	input  exec_pkg::word_t result,
	input  logic            zero,
	input  exec_pkg::addr_t pc,
	input  exec_pkg::word_t imm,
	input  exec_pkg::word_t rs1_data,
	output logic            taken,
	output exec_pkg::addr_t target,
	output exec_pkg::word_t link
);
	import exec_pkg::*;

	logic  cond;
	addr_t jalr_sum;

	// compare outcome per branch kind
	always_comb begin
		case (funct3)
			3'd0: cond = zero;
			3'd1: cond = ~zero;
			// slt / sltu leave the answer in bit 0
			3'd4: cond = result[0];
			3'd5: cond = ~result[0];
			3'd6: cond = result[0];
			3'd7: cond = ~result[0];
			default: cond = 1'b0;
		endcase
	end

	// jumps always redirect, illegal ops already have their flags cleared
	assign taken = (dec.is_branch & cond) | dec.is_jal | dec.is_jalr;

	assign jalr_sum = rs1_data + imm;
	// jalr drops bit 0 of the sum
	assign target = dec.is_jalr ? {jalr_sum[xlen-1:1], 1'b0} : pc + imm;

	// return address for jal / jalr
	assign link = pc + word_t'(4);

endmodule

/* hdl/alu.sv */
// integer alu of the execute stage, computes the result and the zero flag for one operation
`timescale 1ns/1ps

module alu (
	input  exec_pkg::word_t   src1,
	input  exec_pkg::word_t   src2,
	input  exec_pkg::alu_op_t op,
	output exec_pkg::word_t   result,
	output logic              zero
);
	import exec_pkg::*;

	// unsigned difference with carry out on top
	logic [xlen:0] diff_u;
	// sign extended difference, top bit is the signed compare
	logic [xlen:0] diff_s;
	logic          cout;
	logic          lt_u;
	logic          lt_s;
	// shift amount is always masked to five bits
	logic [4:0]    shamt;

	// a - b as a + ~b + 1
	assign diff_u = {1'b0, src1} + {1'b0, ~src2} + {{xlen{1'b0}}, 1'b1};
	assign diff_s = {src1[xlen-1], src1} + ~{src2[xlen-1], src2}
		+ {{xlen{1'b0}}, 1'b1};

	// borrow means src1 < src2 unsigned
	assign cout = diff_u[xlen];
	assign lt_u = ~cout;
	// 33 bit difference cannot overflow
	assign lt_s = diff_s[xlen];

	assign shamt = src2[4:0];

	always_comb begin
		case (op)
			alu_add:    result = src1 + src2;
			alu_sub:    result = diff_u[xlen-1:0];
			alu_sll:    result = src1 << shamt;
			alu_slt:    result = {{(xlen-1){1'b0}}, lt_s};
			alu_sltu:   result = {{(xlen-1){1'b0}}, lt_u};
			alu_xor:    result = src1 ^ src2;
			alu_srl:    result = src1 >> shamt;
			alu_sra:    result = $signed(src1) >>> shamt;
			alu_or:     result = src1 | src2;
			alu_and:    result = src1 & src2;
			alu_pass_b: result = src2;
			default:    result = '0;
		endcase
	end

	// equality from the subtraction, independent of op
	assign zero = (diff_u[xlen-1:0] == '0);

	// only the eleven defined codes may reach the alu
	a_op_defined: assert property (@(op)
		!$isunknown(op) |-> op inside {
			alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor,
			alu_srl, alu_sra, alu_or, alu_and, alu_pass_b
		});

endmodule

/* hdl/imm_gen.sv */
// builds the sign extended immediate of the selected rv32i format from the instruction word
`timescale 1ns/1ps

module imm_gen (
	input  exec_pkg::instr_t   instr,
	input  exec_pkg::imm_fmt_t fmt,
	output exec_pkg::word_t    imm
);
	import exec_pkg::*;

	// every format takes its sign from instruction bit 31
	logic sign;

	assign sign = instr[31];

	always_comb begin
		case (fmt)
			// loads, op-imm, jalr
			imm_i: imm = {{20{sign}}, instr[31:20]};
			// stores, split around rd field
			imm_s: imm = {{20{sign}}, instr[31:25], instr[11:7]};
			// branch offsets, always even
			imm_b: imm = {
				{19{sign}},
				instr[31],
				instr[7],
				instr[30:25],
				instr[11:8],
				1'b0
			};
			// lui / auipc, upper 20 bits
			imm_u: imm = {instr[31:12], 12'b0};
			// jal offsets, scrambled bit order
			imm_j: imm = {
				{11{sign}},
				instr[31],
				instr[19:12],
				instr[20],
				instr[30:21],
				1'b0
			};
			default: imm = '0;
		endcase
	end

endmodule

/* hdl/alu_decoder.sv */
// decodes opcode, funct3 and funct7 into alu operation, operand selects and control flags
`timescale 1ns/1ps

module alu_decoder (
	input  exec_pkg::instr_t instr,
	output exec_pkg::dec_t   dec
);
	import exec_pkg::*;

	opcode_t    opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	reg_idx_t   rd;

	// funct3 to alu op for op and op-imm, alt picks sub / sra
	function automatic alu_op_t arith_op(input logic [2:0] f3, input logic alt);
		alu_op_t op;
		case (f3)
			3'd0: op = alt ? alu_sub : alu_add;
			3'd1: op = alu_sll;
			3'd2: op = alu_slt;
			3'd3: op = alu_sltu;
			3'd4: op = alu_xor;
			3'd5: op = alt ? alu_sra : alu_srl;
			3'd6: op = alu_or;
			default: op = alu_and;
		endcase
		return op;
	endfunction

	assign opcode = instr[6:0];
	assign funct3 = instr[14:12];
	assign funct7 = instr[31:25];
	assign rd     = instr[11:7];

	always_comb begin
		dec = '0;
		dec.alu_op  = alu_add;
		dec.imm_fmt = imm_i;
		case (opcode)
			op_reg: begin
				// alt funct7 only legal for add/sub and srl/sra
				dec.alu_op = arith_op(funct3, funct7[5]);
				dec.rd_wen = 1'b1;
				dec.illegal = !((funct7 == f7_base) ||
					(funct7 == f7_alt && (funct3 == 3'd0 || funct3 == 3'd5)));
			end
			op_imm: begin
				dec.b_is_imm = 1'b1;
				dec.rd_wen   = 1'b1;
				// funct7 only matters for the shifts
				if (funct3 == 3'd1) begin
					dec.alu_op  = alu_sll;
					dec.illegal = (funct7 != f7_base);
				end else if (funct3 == 3'd5) begin
					dec.alu_op  = funct7[5] ? alu_sra : alu_srl;
					dec.illegal = (funct7 != f7_base) && (funct7 != f7_alt);
				end else begin
					dec.alu_op = arith_op(funct3, 1'b0);
				end
			end
			op_lui: begin
				dec.alu_op   = alu_pass_b;
				dec.b_is_imm = 1'b1;
				dec.imm_fmt  = imm_u;
				dec.rd_wen   = 1'b1;
			end
			op_auipc: begin
				dec.a_is_pc  = 1'b1;
				dec.b_is_imm = 1'b1;
				dec.imm_fmt  = imm_u;
				dec.rd_wen   = 1'b1;
			end
			op_branch: begin
				dec.imm_fmt   = imm_b;
				dec.is_branch = 1'b1;
				// eq/ne compare through sub, the rest through the less-than ops
				case (funct3)
					3'd0, 3'd1: dec.alu_op = alu_sub;
					3'd4, 3'd5: dec.alu_op = alu_slt;
					3'd6, 3'd7: dec.alu_op = alu_sltu;
					default:    dec.illegal = 1'b1;
				endcase
			end
			op_jal: begin
				dec.imm_fmt = imm_j;
				dec.is_jal  = 1'b1;
				dec.rd_wen  = 1'b1;
			end
			op_jalr: begin
				dec.is_jalr = 1'b1;
				dec.rd_wen  = 1'b1;
				dec.illegal = (funct3 != 3'd0);
			end
			default: dec.illegal = 1'b1;
		endcase

		// an illegal instruction neither writes nor redirects
		if (dec.illegal) begin
			dec.is_branch = 1'b0;
			dec.is_jal    = 1'b0;
			dec.is_jalr   = 1'b0;
			dec.rd_wen    = 1'b0;
		end
		// x0 is never written
		if (rd == '0)
			dec.rd_wen = 1'b0;
	end

	// write enable must stay off for anything flagged illegal
	a_illegal_no_wen: assert property (@(instr)
		!$isunknown(dec) |-> !(dec.illegal && dec.rd_wen));

endmodule

/* hdl/exec_pkg.sv */
// shared widths, opcodes, alu operation codes and stage structs, imported by every design file
package exec_pkg;

	// data path width
	localparam int xlen = 32;

	typedef logic [xlen-1:0] word_t;
	typedef logic [xlen-1:0] addr_t;
	typedef logic [31:0]     instr_t;
	typedef logic [4:0]      reg_idx_t;
	typedef logic [6:0]      opcode_t;

	// supported rv32i major opcodes
	localparam opcode_t op_reg    = 7'b0110011;
	localparam opcode_t op_imm    = 7'b0010011;
	localparam opcode_t op_lui    = 7'b0110111;
	localparam opcode_t op_auipc  = 7'b0010111;
	localparam opcode_t op_branch = 7'b1100011;
	localparam opcode_t op_jal    = 7'b1101111;
	localparam opcode_t op_jalr   = 7'b1100111;

	// the two funct7 values that carry meaning for op and op-imm
	localparam logic [6:0] f7_base = 7'h00;
	localparam logic [6:0] f7_alt  = 7'h20;

	// alu operation codes
	typedef enum logic [3:0] {
		alu_add    = 4'd0,
		alu_sub    = 4'd1,
		alu_sll    = 4'd2,
		alu_slt    = 4'd3,
		alu_sltu   = 4'd4,
		alu_xor    = 4'd5,
		alu_srl    = 4'd6,
		alu_sra    = 4'd7,
		alu_or     = 4'd8,
		alu_and    = 4'd9,
		alu_pass_b = 4'd10
	} alu_op_t;

	// immediate layouts
	typedef enum logic [2:0] {
		imm_i,
		imm_s,
		imm_b,
		imm_u,
		imm_j
	} imm_fmt_t;

	// decode result
	typedef struct packed {
		alu_op_t  alu_op;
		logic     a_is_pc;
		logic     b_is_imm;
		imm_fmt_t imm_fmt;
		logic     is_branch;
		logic     is_jal;
		logic     is_jalr;
		logic     rd_wen;
		logic     illegal;
	} dec_t;

	// instruction entering the stage
	typedef struct packed {
		logic   valid;
		instr_t instr;
		addr_t  pc;
		word_t  rs1_data;
		word_t  rs2_data;
	} exec_in_t;

	// registered outcome of the stage
	typedef struct packed {
		logic     valid;
		reg_idx_t rd;
		logic     rd_wen;
		word_t    rd_data;
		logic     redirect;
		addr_t    target;
		logic     illegal;
	} exec_out_t;

endpackage
